// File: logic/rv_pkg.sv
`default_nettype none

package rv_pkg;

  typedef logic [31:0] word_t;     // register values, immediates, memory data
  typedef logic [4:0]  reg_addr_t;
  typedef logic [31:0] pc_t;       // byte address

  // execute-stage operations
  typedef enum logic [2:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_SLT,
    ALU_PASS_B   // lui
  } alu_op_t;

  // operand source in execute
  typedef enum logic [1:0] {
    FWD_ID_EX,
    FWD_EX_MEM,
    FWD_MEM_WB
  } fwd_sel_t;

  localparam logic [6:0] OP_R      = 7'b0110011;
  localparam logic [6:0] OP_I      = 7'b0010011;
  localparam logic [6:0] OP_LOAD   = 7'b0000011;
  localparam logic [6:0] OP_STORE  = 7'b0100011;
  localparam logic [6:0] OP_BRANCH = 7'b1100011;
  localparam logic [6:0] OP_LUI    = 7'b0110111;

endpackage

`default_nettype wire

// File: logic/rv_imem.sv
`timescale 1ns/1ps
`default_nettype none

module rv_imem import rv_pkg::*; #(
  parameter int IMEM_DEPTH = 64
) (
  input  logic                          clk,
  input  logic                          imem_we,
  input  logic [$clog2(IMEM_DEPTH)-1:0] imem_addr,  // word index
  input  word_t                         imem_wdata,
  input  pc_t                           fetch_pc,
  output word_t                         instr
);

  localparam int AW = $clog2(IMEM_DEPTH);

  word_t mem [IMEM_DEPTH];

  always_ff @(posedge clk) begin
    if (imem_we) mem[imem_addr] <= imem_wdata;
  end

  // out of range fetch gives zero, decoded as a nop
  assign instr = (fetch_pc[31:2] < IMEM_DEPTH) ? mem[fetch_pc[AW+1:2]] : '0;

endmodule

`default_nettype wire

// File: logic/rv_regfile.sv
`timescale 1ns/1ps
`default_nettype none

module rv_regfile import rv_pkg::*; (
  input  logic      clk,
  input  logic      rst_n,
  input  reg_addr_t rs1,
  input  reg_addr_t rs2,
  input  reg_addr_t rd,
  input  logic      rd_we,
  input  word_t     rd_data,
  output word_t     rs1_data,
  output word_t     rs2_data
);

  word_t regs [32];

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      for (int i = 0; i < 32; i++) regs[i] <= '0;
    end else if (rd_we && rd != '0) begin
      regs[rd] <= rd_data;
    end
  end

  // same-cycle write shows up on the read side
  assign rs1_data = (rs1 == '0)              ? '0      :
                    (rd_we && rd == rs1)     ? rd_data : regs[rs1];
  assign rs2_data = (rs2 == '0)              ? '0      :
                    (rd_we && rd == rs2)     ? rd_data : regs[rs2];

endmodule

`default_nettype wire

// File: logic/rv_alu.sv
`timescale 1ns/1ps
`default_nettype none

module rv_alu import rv_pkg::*; (
  input  word_t   a,
  input  word_t   b,
  input  alu_op_t op,
  output word_t   result,
  output logic    zero
);

  always_comb begin
    case (op)
      ALU_ADD:    result = a + b;
      ALU_SUB:    result = a - b;
      ALU_AND:    result = a & b;
      ALU_OR:     result = a | b;
      ALU_SLT:    result = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      ALU_PASS_B: result = b;
      default:    result = '0;
    endcase
  end

  // beq runs as sub, equal operands give zero
  assign zero = (result == '0);

endmodule

`default_nettype wire

// File: logic/rv_forward.sv
`timescale 1ns/1ps
`default_nettype none

module rv_forward import rv_pkg::*; (
  input  reg_addr_t ex_rs1,
  input  reg_addr_t ex_rs2,
  input  word_t     ex_a,
  input  word_t     ex_b,
  input  reg_addr_t mem_rd,
  input  logic      mem_reg_we,
  input  word_t     mem_result,
  input  reg_addr_t wb_rd,
  input  logic      wb_reg_we,
  input  word_t     wb_data,
  output word_t     op_a,
  output word_t     op_b
);

  fwd_sel_t sel_a;
  fwd_sel_t sel_b;

  // youngest producer wins
  always_comb begin
    sel_a = FWD_ID_EX;
    if (mem_reg_we && mem_rd != '0 && mem_rd == ex_rs1) sel_a = FWD_EX_MEM;
    else if (wb_reg_we && wb_rd != '0 && wb_rd == ex_rs1) sel_a = FWD_MEM_WB;

    sel_b = FWD_ID_EX;
    if (mem_reg_we && mem_rd != '0 && mem_rd == ex_rs2) sel_b = FWD_EX_MEM;
    else if (wb_reg_we && wb_rd != '0 && wb_rd == ex_rs2) sel_b = FWD_MEM_WB;
  end

  always_comb begin
    case (sel_a)
      FWD_EX_MEM: op_a = mem_result;
      FWD_MEM_WB: op_a = wb_data;
      default:    op_a = ex_a;
    endcase
    case (sel_b)
      FWD_EX_MEM: op_b = mem_result;
      FWD_MEM_WB: op_b = wb_data;
      default:    op_b = ex_b;   // also the store data
    endcase
  end

endmodule

`default_nettype wire

// File: logic/rv_control.sv
`timescale 1ns/1ps
`default_nettype none

module rv_control import rv_pkg::*; (
  input  logic      clk,
  input  logic      rst_n,
  input  logic      enable,
  input  word_t     instr,
  input  logic      ex_mem_read,   // load sitting in execute
  input  reg_addr_t ex_rd,
  input  logic      branch_taken,
  output reg_addr_t rs1,
  output reg_addr_t rs2,
  output reg_addr_t rd,
  output word_t     imm,
  output alu_op_t   alu_op,
  output logic      alu_src_imm,
  output logic      mem_read,
  output logic      mem_write,
  output logic      reg_we,
  output logic      is_branch,
  output logic      stall,
  output logic      flush
);

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic       uses_rs1;
  logic       uses_rs2;
  logic       flush_q;

  assign opcode = instr[6:0];
  assign funct3 = instr[14:12];
  assign rd     = instr[11:7];
  assign rs1    = instr[19:15];
  assign rs2    = instr[24:20];

  always_comb begin
    imm         = '0;
    alu_op      = ALU_ADD;
    alu_src_imm = 1'b0;
    mem_read    = 1'b0;
    mem_write   = 1'b0;
    reg_we      = 1'b0;
    is_branch   = 1'b0;
    uses_rs1    = 1'b0;
    uses_rs2    = 1'b0;
    case (opcode)
      OP_R: begin
        uses_rs1 = 1'b1;
        uses_rs2 = 1'b1;
        reg_we   = 1'b1;
        case (funct3)
          3'b000:  alu_op = instr[30] ? ALU_SUB : ALU_ADD;
          3'b010:  alu_op = ALU_SLT;
          3'b110:  alu_op = ALU_OR;
          3'b111:  alu_op = ALU_AND;
          default: reg_we = 1'b0;   // unsupported funct, nop
        endcase
      end
      OP_I: begin
        uses_rs1    = 1'b1;
        alu_src_imm = 1'b1;
        reg_we      = (funct3 == 3'b000);   // addi only
        imm         = {{20{instr[31]}}, instr[31:20]};
      end
      OP_LOAD: begin
        uses_rs1    = 1'b1;
        alu_src_imm = 1'b1;
        mem_read    = 1'b1;
        reg_we      = 1'b1;
        imm         = {{20{instr[31]}}, instr[31:20]};
      end
      OP_STORE: begin
        uses_rs1    = 1'b1;
        uses_rs2    = 1'b1;
        alu_src_imm = 1'b1;
        mem_write   = 1'b1;
        imm         = {{20{instr[31]}}, instr[31:25], instr[11:7]};
      end
      OP_BRANCH: begin
        uses_rs1  = 1'b1;
        uses_rs2  = 1'b1;
        alu_op    = ALU_SUB;
        is_branch = (funct3 == 3'b000);     // beq only
        imm       = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
      end
      OP_LUI: begin
        alu_op      = ALU_PASS_B;
        alu_src_imm = 1'b1;
        reg_we      = 1'b1;
        imm         = {instr[31:12], 12'b0};
      end
      default: ;  // unknown opcode acts as nop
    endcase
  end

  // one flush per taken branch, kept pending while the pipe is frozen
  assign flush = branch_taken & ~flush_q;

  assign stall = ~flush & ex_mem_read & (ex_rd != '0) &
                 ((uses_rs1 & (ex_rd == rs1)) | (uses_rs2 & (ex_rd == rs2)));

  always_ff @(posedge clk) begin
    if (!rst_n) flush_q <= 1'b0;
    else if (enable) flush_q <= flush;
  end

endmodule

`default_nettype wire

// File: logic/rv_core.sv
`timescale 1ns/1ps
`default_nettype none

module rv_core import rv_pkg::*; #(
  parameter int IMEM_DEPTH = 64
) (
  input  logic                          clk,
  input  logic                          rst_n,
  input  logic                          enable,
  input  logic                          imem_we,
  input  logic [$clog2(IMEM_DEPTH)-1:0] imem_addr,
  input  word_t                         imem_wdata,
  output logic                          dmem_rd,
  output logic                          dmem_wr,
  output word_t                         dmem_addr,
  output word_t                         dmem_wdata,
  input  word_t                         dmem_rdata
);

  pc_t   pc;
  word_t fetch_instr;

  // IF/ID
  logic  if_id_valid;
  pc_t   if_id_pc;
  word_t if_id_instr;

  // decode outputs
  reg_addr_t id_rs1, id_rs2, id_rd;
  word_t     id_imm, id_rs1_data, id_rs2_data;
  alu_op_t   id_alu_op;
  logic      id_alu_src_imm, id_mem_read, id_mem_write, id_reg_we, id_is_branch;
  logic      stall, flush;

  // ID/EX
  logic      id_ex_valid;
  pc_t       id_ex_pc;
  reg_addr_t id_ex_rs1, id_ex_rs2, id_ex_rd;
  word_t     id_ex_imm, id_ex_a, id_ex_b;
  alu_op_t   id_ex_alu_op;
  logic      id_ex_alu_src_imm, id_ex_mem_read, id_ex_mem_write, id_ex_reg_we;
  logic      id_ex_is_branch;

  // execute
  word_t op_a, op_b, alu_b, alu_result;
  logic  alu_zero, branch_taken;
  pc_t   branch_target;

  // EX/MEM
  logic      ex_mem_valid;
  word_t     ex_mem_result, ex_mem_store_data;
  reg_addr_t ex_mem_rd;
  logic      ex_mem_mem_read, ex_mem_mem_write, ex_mem_reg_we;

  // MEM/WB
  logic      mem_wb_valid;
  word_t     mem_wb_result, mem_wb_load;
  reg_addr_t mem_wb_rd;
  logic      mem_wb_mem_read, mem_wb_reg_we;
  word_t     wb_data;
  logic      wb_we;

  rv_imem #(.IMEM_DEPTH(IMEM_DEPTH)) imem_i (
    .clk(clk), .imem_we(imem_we), .imem_addr(imem_addr), .imem_wdata(imem_wdata),
    .fetch_pc(pc), .instr(fetch_instr)
  );

  always_ff @(posedge clk) begin
    if (!rst_n) pc <= '0;
    else if (enable) begin
      if (flush) pc <= branch_target;
      else if (!stall) pc <= pc + 32'd4;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) if_id_valid <= 1'b0;
    else if (enable) begin
      if (flush) if_id_valid <= 1'b0;
      else if (!stall) if_id_valid <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (enable && !stall) begin
      if_id_pc    <= pc;
      if_id_instr <= fetch_instr;
    end
  end

  rv_control control_i (
    .clk(clk), .rst_n(rst_n), .enable(enable), .instr(if_id_instr),
    .ex_mem_read(id_ex_valid & id_ex_mem_read), .ex_rd(id_ex_rd),
    .branch_taken(branch_taken),
    .rs1(id_rs1), .rs2(id_rs2), .rd(id_rd), .imm(id_imm), .alu_op(id_alu_op),
    .alu_src_imm(id_alu_src_imm), .mem_read(id_mem_read), .mem_write(id_mem_write),
    .reg_we(id_reg_we), .is_branch(id_is_branch), .stall(stall), .flush(flush)
  );

  rv_regfile regfile_i (
    .clk(clk), .rst_n(rst_n), .rs1(id_rs1), .rs2(id_rs2),
    .rd(mem_wb_rd), .rd_we(enable & wb_we), .rd_data(wb_data),
    .rs1_data(id_rs1_data), .rs2_data(id_rs2_data)
  );

  // bubble on stall or flush
  always_ff @(posedge clk) begin
    if (!rst_n) id_ex_valid <= 1'b0;
    else if (enable) id_ex_valid <= if_id_valid & ~stall & ~flush;
  end

  always_ff @(posedge clk) begin
    if (enable) begin
      id_ex_pc          <= if_id_pc;
      id_ex_rs1         <= id_rs1;
      id_ex_rs2         <= id_rs2;
      id_ex_rd          <= id_rd;
      id_ex_imm         <= id_imm;
      id_ex_a           <= id_rs1_data;
      id_ex_b           <= id_rs2_data;
      id_ex_alu_op      <= id_alu_op;
      id_ex_alu_src_imm <= id_alu_src_imm;
      id_ex_mem_read    <= id_mem_read;
      id_ex_mem_write   <= id_mem_write;
      id_ex_reg_we      <= id_reg_we;
      id_ex_is_branch   <= id_is_branch;
    end
  end

  rv_forward forward_i (
    .ex_rs1(id_ex_rs1), .ex_rs2(id_ex_rs2), .ex_a(id_ex_a), .ex_b(id_ex_b),
    .mem_rd(ex_mem_rd), .mem_reg_we(ex_mem_valid & ex_mem_reg_we), .mem_result(ex_mem_result),
    .wb_rd(mem_wb_rd), .wb_reg_we(wb_we), .wb_data(wb_data),
    .op_a(op_a), .op_b(op_b)
  );

  assign alu_b = id_ex_alu_src_imm ? id_ex_imm : op_b;

  rv_alu alu_i (
    .a(op_a), .b(alu_b), .op(id_ex_alu_op), .result(alu_result), .zero(alu_zero)
  );

  assign branch_taken  = id_ex_valid & id_ex_is_branch & alu_zero;
  assign branch_target = id_ex_pc + id_ex_imm;

  always_ff @(posedge clk) begin
    if (!rst_n) ex_mem_valid <= 1'b0;
    else if (enable) ex_mem_valid <= id_ex_valid;
  end

  always_ff @(posedge clk) begin
    if (enable) begin
      ex_mem_result     <= alu_result;
      ex_mem_store_data <= op_b;   // forwarded rs2
      ex_mem_rd         <= id_ex_rd;
      ex_mem_mem_read   <= id_ex_mem_read;
      ex_mem_mem_write  <= id_ex_mem_write;
      ex_mem_reg_we     <= id_ex_reg_we;
    end
  end

  // single-cycle strobes, low while frozen
  assign dmem_rd    = enable & ex_mem_valid & ex_mem_mem_read;
  assign dmem_wr    = enable & ex_mem_valid & ex_mem_mem_write;
  assign dmem_addr  = ex_mem_result;
  assign dmem_wdata = ex_mem_store_data;

  always_ff @(posedge clk) begin
    if (!rst_n) mem_wb_valid <= 1'b0;
    else if (enable) mem_wb_valid <= ex_mem_valid;
  end

  always_ff @(posedge clk) begin
    if (enable) begin
      mem_wb_result   <= ex_mem_result;
      mem_wb_load     <= dmem_rdata;
      mem_wb_rd       <= ex_mem_rd;
      mem_wb_mem_read <= ex_mem_mem_read;
      mem_wb_reg_we   <= ex_mem_reg_we;
    end
  end

  assign wb_data = mem_wb_mem_read ? mem_wb_load : mem_wb_result;
  assign wb_we   = mem_wb_valid & mem_wb_reg_we;

endmodule

`default_nettype wire

// File: testbench/rv_core_props.sv
`timescale 1ns/1ps
`default_nettype none

module rv_core_props import rv_pkg::*; (
  input logic clk,
  input logic rst_n,
  input logic stall,
  input pc_t  pc,
  input logic dmem_rd,
  input logic dmem_wr
);

  // one data access per cycle at most
  strobe_exclusive: assert property (@(posedge clk) !(dmem_rd && dmem_wr))
    else $error("dmem_rd and dmem_wr high in the same cycle");

  strobe_quiet_in_reset: assert property (@(posedge clk) !rst_n |-> (!dmem_rd && !dmem_wr))
    else $error("data strobe high during reset");

  // load-use bubble keeps fetch in place
  pc_hold_on_stall: assert property (
    @(posedge clk) disable iff (!rst_n) stall |=> (pc == $past(pc))
  ) else $error("pc moved during a stall");

endmodule

`default_nettype wire

// File: testbench/tb_rv_core.sv
`timescale 1ns/1ps
`default_nettype none

module tb_rv_core import rv_pkg::*; ();

  localparam int IMEM_DEPTH  = 64;
  localparam int IMEM_AW     = $clog2(IMEM_DEPTH);
  localparam int NUM_INSTR   = 31;
  localparam int NUM_STORES  = 12;
  localparam int NUM_LOADS   = 1;
  localparam int CYCLE_LIMIT = 4 * NUM_INSTR + 50;

  localparam word_t LOAD_ADDR = 32'd20;   // lw x7, 20(x0)

  // RV32I major opcodes
  localparam logic [6:0] OPC_R      = 7'b0110011;
  localparam logic [6:0] OPC_I      = 7'b0010011;
  localparam logic [6:0] OPC_LOAD   = 7'b0000011;
  localparam logic [6:0] OPC_STORE  = 7'b0100011;
  localparam logic [6:0] OPC_BRANCH = 7'b1100011;
  localparam logic [6:0] OPC_LUI    = 7'b0110111;

  logic               clk;
  logic               rst_n;
  logic               enable;
  logic               imem_we;
  logic [IMEM_AW-1:0] imem_addr;
  word_t              imem_wdata;
  logic               dmem_rd;
  logic               dmem_wr;
  word_t              dmem_addr;
  word_t              dmem_wdata;
  word_t              dmem_rdata;

  word_t prog [NUM_INSTR];
  word_t exp_addr [NUM_STORES];
  word_t exp_data [NUM_STORES];
  word_t dmem [16];         // data memory model
  int    store_idx;
  int    loads;
  int    mismatches;
  int    failures;
  int    cycles;

  rv_core #(.IMEM_DEPTH(IMEM_DEPTH)) rv_core_i (
    .clk(clk), .rst_n(rst_n), .enable(enable),
    .imem_we(imem_we), .imem_addr(imem_addr), .imem_wdata(imem_wdata),
    .dmem_rd(dmem_rd), .dmem_wr(dmem_wr), .dmem_addr(dmem_addr),
    .dmem_wdata(dmem_wdata), .dmem_rdata(dmem_rdata)
  );

  bind rv_core rv_core_props props_i (
    .clk(clk), .rst_n(rst_n), .stall(stall), .pc(pc), .dmem_rd(dmem_rd), .dmem_wr(dmem_wr)
  );

  assign dmem_rdata = dmem_rd ? dmem[dmem_addr[5:2]] : '0;  // same-cycle read data

  function automatic word_t enc_r(logic [6:0] funct7, logic [4:0] rs2, logic [4:0] rs1,
                                 logic [2:0] funct3, logic [4:0] rd);
    return {funct7, rs2, rs1, funct3, rd, OPC_R};
  endfunction

  function automatic word_t enc_i(logic [11:0] imm, logic [4:0] rs1, logic [2:0] funct3,
                                 logic [4:0] rd, logic [6:0] opcode);
    return {imm, rs1, funct3, rd, opcode};
  endfunction

  function automatic word_t enc_s(logic [11:0] imm, logic [4:0] rs2, logic [4:0] rs1);
    return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], OPC_STORE};  // sw
  endfunction

  function automatic word_t enc_b(logic [12:0] off, logic [4:0] rs2, logic [4:0] rs1);
    return {off[12], off[10:5], rs2, rs1, 3'b000, off[4:1], off[11], OPC_BRANCH};  // beq
  endfunction

  function automatic word_t enc_u(logic [19:0] imm, logic [4:0] rd);
    return {imm, rd, OPC_LUI};
  endfunction

  task automatic set_store(int idx, word_t addr, word_t data);
    exp_addr[idx] = addr;
    exp_data[idx] = data;
  endtask

  task automatic fill_tables();
    // dependent ALU chain, x1 = 13
    prog[0]  = enc_i(12'd13, 5'd0, 3'b000, 5'd1, OPC_I);
    prog[1]  = enc_r(7'h00, 5'd1, 5'd1, 3'b000, 5'd2);        // add x2, x1, x1
    prog[2]  = enc_r(7'h20, 5'd1, 5'd2, 3'b000, 5'd3);        // sub x3, x2, x1
    prog[3]  = enc_r(7'h00, 5'd3, 5'd2, 3'b111, 5'd4);        // and x4, x2, x3
    prog[4]  = enc_r(7'h00, 5'd2, 5'd3, 3'b110, 5'd5);        // or  x5, x3, x2
    prog[5]  = enc_r(7'h00, 5'd2, 5'd3, 3'b010, 5'd6);        // slt x6, x3, x2
    prog[6]  = enc_s(12'd16, 5'd6, 5'd0);                      // store data forwarded
    prog[7]  = enc_s(12'd0, 5'd2, 5'd0);
    prog[8]  = enc_s(12'd4, 5'd3, 5'd0);
    prog[9]  = enc_s(12'd8, 5'd4, 5'd0);
    prog[10] = enc_s(12'd12, 5'd5, 5'd0);
    // load-use
    prog[11] = enc_s(12'd20, 5'd5, 5'd0);
    prog[12] = enc_i(12'd20, 5'd0, 3'b010, 5'd7, OPC_LOAD);   // lw x7, 20(x0)
    prog[13] = enc_i(12'd100, 5'd7, 3'b000, 5'd8, OPC_I);
    prog[14] = enc_s(12'd24, 5'd8, 5'd0);
    // x9 read three slots after its write
    prog[15] = enc_i(12'd77, 5'd0, 3'b000, 5'd9, OPC_I);
    prog[16] = enc_i(12'hfff, 5'd0, 3'b000, 5'd12, OPC_I);    // marker x12 = -1
    prog[17] = enc_i(12'd2, 5'd0, 3'b000, 5'd11, OPC_I);
    prog[18] = enc_s(12'd28, 5'd9, 5'd0);
    prog[19] = enc_i(12'd55, 5'd0, 3'b000, 5'd0, OPC_I);      // write to x0
    prog[20] = enc_s(12'd32, 5'd0, 5'd0);
    prog[21] = enc_b(13'd12, 5'd3, 5'd1);                      // taken, to prog[24]
    prog[22] = enc_s(12'd36, 5'd12, 5'd0);
    prog[23] = enc_s(12'd36, 5'd12, 5'd0);
    prog[24] = enc_i(12'd42, 5'd0, 3'b000, 5'd13, OPC_I);
    prog[25] = enc_s(12'd40, 5'd13, 5'd0);
    prog[26] = enc_b(13'd8, 5'd2, 5'd1);                       // not taken
    prog[27] = enc_s(12'd44, 5'd13, 5'd0);
    prog[28] = enc_u(20'h12345, 5'd14);
    prog[29] = enc_i(12'hfff, 5'd14, 3'b000, 5'd14, OPC_I);
    prog[30] = enc_s(12'd48, 5'd14, 5'd0);

    set_store(0, 32'd16, 32'd1);
    set_store(1, 32'd0, 32'd26);
    set_store(2, 32'd4, 32'd13);
    set_store(3, 32'd8, 32'd8);
    set_store(4, 32'd12, 32'd31);
    set_store(5, 32'd20, 32'd31);
    set_store(6, 32'd24, 32'd131);
    set_store(7, 32'd28, 32'd77);
    set_store(8, 32'd32, 32'd0);
    set_store(9, 32'd40, 32'd42);
    set_store(10, 32'd44, 32'd42);
    set_store(11, 32'd48, 32'h1234_4fff);   // 0x12345000 - 1
  endtask

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // stores are stable by the falling edge
  always @(negedge clk) begin
    if (dmem_rd) begin
      assert (dmem_addr == LOAD_ADDR) else begin
        mismatches++;
        $display("MISMATCH at %0t: load expected from 0x%08h, got 0x%08h",
                 $time, LOAD_ADDR, dmem_addr);
      end
      loads++;
    end
    if (dmem_wr) begin
      assert (store_idx < NUM_STORES) else begin
        failures++;
        $display("unexpected extra store at %0t to address 0x%08h", $time, dmem_addr);
      end
      if (store_idx < NUM_STORES) begin
        assert (dmem_addr == exp_addr[store_idx] && dmem_wdata == exp_data[store_idx])
        else begin
          mismatches++;
          $display("MISMATCH at %0t: store %0d expected [0x%08h] = 0x%08h, got [0x%08h] = 0x%08h",
                   $time, store_idx, exp_addr[store_idx], exp_data[store_idx],
                   dmem_addr, dmem_wdata);
        end
      end
      dmem[dmem_addr[5:2]] = dmem_wdata;
      store_idx++;
    end
  end

  initial begin
    rst_n      = 1'b0;
    enable     = 1'b0;
    imem_we    = 1'b0;
    imem_addr  = '0;
    imem_wdata = '0;
    store_idx  = 0;
    loads      = 0;
    mismatches = 0;
    failures   = 0;
    cycles     = 0;
    fill_tables();
    for (int i = 0; i < 16; i++) dmem[i] = 32'hd0d0_0000 + 32'(i);

    @(posedge clk);
    #1;
    enable = 1'b1;   // pipeline clocked under reset, strobes must stay low
    repeat (4) @(posedge clk);
    #1;
    rst_n  = 1'b1;
    enable = 1'b0;

    // load the whole imem, unused words as addi x0 nops
    for (int i = 0; i < IMEM_DEPTH; i++) begin
      @(posedge clk);
      #1;
      imem_we    = 1'b1;
      imem_addr  = i[IMEM_AW-1:0];
      imem_wdata = (i < NUM_INSTR) ? prog[i] : enc_i(i[11:0], 5'd0, 3'b000, 5'd0, OPC_I);
    end
    @(posedge clk);
    #1;
    imem_we = 1'b0;
    enable  = 1'b1;

    while (store_idx < NUM_STORES && cycles < CYCLE_LIMIT) begin
      @(posedge clk);
      cycles++;
    end
    assert (store_idx >= NUM_STORES) else begin
      failures++;
      $display("timeout after %0d cycles, only %0d of %0d expected stores arrived",
               cycles, store_idx, NUM_STORES);
    end
    assert (loads == NUM_LOADS) else begin
      failures++;
      $display("expected %0d data load, saw %0d", NUM_LOADS, loads);
    end

    $display("summary: %0d mismatches, %0d other failures", mismatches, failures);
    if (mismatches == 0 && failures == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: tb.f
logic/rv_pkg.sv
logic/rv_imem.sv
logic/rv_regfile.sv
logic/rv_alu.sv
logic/rv_forward.sv
logic/rv_control.sv
logic/rv_core.sv
testbench/rv_core_props.sv
testbench/tb_rv_core.sv

// File: run_sim.sh
#!/bin/sh
# build the rv_core testbench with Verilator, run it, check the log

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_rv_core -f tb.f -o tb_rv_core
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/tb_rv_core > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -qx "TEST OK" "$LOG"; then
  exit 0
fi
echo "pass line not found in $LOG"
exit 1
